//--- project.f
adpll_pkg.sv
adpll_nco.sv
adpll_phase_detector.sv
adpll_loop_filter.sv
adpll_lock_detector.sv
adpll_top.sv
adpll_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ADPLL testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module adpll_tb \
	--Mdir obj_dir -o adpll_sim

./obj_dir/adpll_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	echo "simulation result: PASS"
else
	echo "simulation result: FAIL"
	exit 1
fi

//--- adpll_tb.sv
`timescale 1ns/1ps

module adpll_tb;

	localparam int NUM_ROWS = 5;
	localparam int LOCK_TOL = 2;
	localparam int LOCK_COUNT = 8;
	localparam int FULL_SCALE = 2 ** adpll_pkg::PHASE_WIDTH;
	localparam int CC_LIMIT = 2 ** (adpll_pkg::DCO_CC_WIDTH - 1);
	localparam int INTEG_LIMIT = 2 ** (adpll_pkg::INTEG_WIDTH - 1);

	logic               gen_clk_i;
	logic               reset_i;
	logic               ref_tick_i;
	adpll_pkg::phase_t  fcw_i;
	adpll_pkg::kp_t     kp_i;
	adpll_pkg::ki_t     ki_i;
	adpll_pkg::dco_cc_t dco_cc_o;
	logic               nco_tick_o;
	logic               lock_o;

	// open loop, matched lock, detuned period, integral path, saturation
	int row_fcw    [NUM_ROWS] = '{3000, 1024, 1024, 1536, 4608};
	int row_kp     [NUM_ROWS] = '{0, 7, 7, 2, 7};
	int row_ki     [NUM_ROWS] = '{0, 0, 0, 1, 15};
	int row_period [NUM_ROWS] = '{50, 64, 70, 64, 64};
	int row_ticks  [NUM_ROWS] = '{20, 40, 20, 25, 30};
	int row_lock   [NUM_ROWS] = '{0, 1, 0, 0, 0};

	// reference model state, all zero out of reset
	int m_phase = 0;
	int m_tick = 0;
	int m_valid = 0;
	int m_err = 0;
	int m_err_q = 0;
	int m_integ = 0;
	int m_run = 0;
	int m_lock = 0;
	int error_count = 0;
	int check_count = 0;

	adpll_top #(
		.DYNAMIC_GAIN (1),
		.LOCK_TOL     (LOCK_TOL),
		.LOCK_COUNT   (LOCK_COUNT)
	) i_adpll_top (
		.gen_clk_i  (gen_clk_i),
		.reset_i    (reset_i),
		.ref_tick_i (ref_tick_i),
		.fcw_i      (fcw_i),
		.kp_i       (kp_i),
		.ki_i       (ki_i),
		.dco_cc_o   (dco_cc_o),
		.nco_tick_o (nco_tick_o),
		.lock_o     (lock_o)
	);

	always #2 gen_clk_i = ~gen_clk_i;

	// kp carries one fraction bit and the integrator three
	function automatic int model_cc(input int kp);
		int sum;
		int cc;
		sum = m_integ + m_err_q * kp * 4;
		cc = sum >>> adpll_pkg::KI_FRAC_WIDTH;
		if (cc > CC_LIMIT - 1)
			cc = CC_LIMIT - 1;
		else if (cc < -CC_LIMIT)
			cc = -CC_LIMIT;
		return cc;
	endfunction

	// one rising edge of the loop, inputs as applied before the edge
	task automatic advance_model();
		int acc;
		int sample;
		int abs_err;
		acc = m_phase + int'(fcw_i) + model_cc(int'(kp_i));
		if (m_valid != 0)
		begin
			abs_err = (m_err < 0) ? -m_err : m_err;
			if (abs_err <= LOCK_TOL)
			begin
				if (m_run >= LOCK_COUNT - 1)
					m_lock = 1;
				if (m_run < LOCK_COUNT)
					m_run = m_run + 1;
			end
			else
			begin
				m_run = 0;
				m_lock = 0;
			end
			m_err_q = m_err;
			m_integ = m_integ + m_err * int'(ki_i);
			if (m_integ > INTEG_LIMIT - 1)
				m_integ = INTEG_LIMIT - 1;
			else if (m_integ < -INTEG_LIMIT)
				m_integ = -INTEG_LIMIT;
		end
		// top eight phase bits as a signed fraction of a turn
		sample = m_phase >> (adpll_pkg::PHASE_WIDTH - adpll_pkg::ERROR_WIDTH);
		if (sample >= 128)
			sample = sample - 256;
		m_valid = int'(ref_tick_i);
		if (ref_tick_i)
			m_err = (sample == -128) ? 127 : -sample;
		m_tick = (acc >= FULL_SCALE) ? 1 : 0;
		m_phase = ((acc % FULL_SCALE) + FULL_SCALE) % FULL_SCALE;
	endtask

	task automatic check_cc(input adpll_pkg::dco_cc_t got, input adpll_pkg::dco_cc_t exp);
		check_count = check_count + 1;
		if (got !== exp)
		begin
			error_count = error_count + 1;
			$display("FAILED at %0t ns: dco_cc_o is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_lock(input logic got, input logic exp);
		check_count = check_count + 1;
		if (got !== exp)
		begin
			error_count = error_count + 1;
			$display("FAILED at %0t ns: lock_o is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_tick_count(input integer got, input integer exp);
		check_count = check_count + 1;
		if (got !== exp)
		begin
			error_count = error_count + 1;
			$display("FAILED at %0t ns: %0d NCO ticks, expected %0d", $time, got, exp);
		end
	endtask

	// watchdog sized from the table plus a margin per row
	initial
	begin
		int limit_cycles;
		int r;
		limit_cycles = 200;
		for (r = 0; r < NUM_ROWS; r++)
			limit_cycles = limit_cycles + (row_ticks[r] + 1) * row_period[r];
		#(limit_cycles * 4);
		$display("run timed out after %0d cycles", limit_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		int r;
		int c;
		int offset;
		int row_cycles;
		int dut_ticks;
		int model_ticks;
		void'($urandom(18));
		gen_clk_i = 1'b0;
		reset_i = 1'b1;
		ref_tick_i = 1'b0;
		fcw_i = '0;
		kp_i = '0;
		ki_i = '0;
		repeat (10) @(negedge gen_clk_i);
		check_cc(dco_cc_o, '0);
		check_lock(lock_o, 1'b0);
		reset_i = 1'b0;
		for (r = 0; r < NUM_ROWS; r++)
		begin
			fcw_i = adpll_pkg::phase_t'(row_fcw[r]);
			kp_i = adpll_pkg::kp_t'(row_kp[r]);
			ki_i = adpll_pkg::ki_t'(row_ki[r]);
			offset = $urandom_range(row_period[r] - 1, 0);
			row_cycles = offset + row_ticks[r] * row_period[r];
			dut_ticks = 0;
			model_ticks = 0;
			for (c = 0; c < row_cycles; c++)
			begin
				ref_tick_i = (c >= offset) && ((c - offset) % row_period[r] == 0);
				@(negedge gen_clk_i);
				advance_model();
				dut_ticks = dut_ticks + int'(nco_tick_o);
				model_ticks = model_ticks + m_tick;
				check_cc(dco_cc_o, adpll_pkg::dco_cc_t'(model_cc(int'(kp_i))));
				check_lock(lock_o, m_lock != 0);
			end
			ref_tick_i = 1'b0;
			check_tick_count(dut_ticks, model_ticks);
			// lock state the row is built to reach
			check_lock(lock_o, row_lock[r] != 0);
			$display("row %0d done: fcw %0d, kp %0d, ki %0d, nco ticks %0d, lock %b, errors %0d",
				r, row_fcw[r], row_kp[r], row_ki[r], dut_ticks, lock_o, error_count);
		end
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- adpll_top.sv
`timescale 1ns/1ps

module adpll_top
#(
	parameter int             DYNAMIC_GAIN = 1,
	parameter adpll_pkg::kp_t KP = 3'b001,
	parameter adpll_pkg::ki_t KI = 4'b0001,
	parameter int             LOCK_TOL = 2,
	parameter int             LOCK_COUNT = 8
)
(
	input  logic               gen_clk_i,
	input  logic               reset_i,
	input  logic               ref_tick_i,
	input  adpll_pkg::phase_t  fcw_i,
	input  adpll_pkg::kp_t     kp_i,
	input  adpll_pkg::ki_t     ki_i,
	output adpll_pkg::dco_cc_t dco_cc_o,
	output logic               nco_tick_o,
	output logic               lock_o
);

	adpll_pkg::phase_t phase;
	adpll_pkg::error_t err;
	logic              err_valid;

	adpll_nco i_nco (
		.gen_clk_i (gen_clk_i),
		.reset_i   (reset_i),
		.fcw_i     (fcw_i),
		.dco_cc_i  (dco_cc_o),
		.phase_o   (phase),
		.tick_o    (nco_tick_o)
	);

	adpll_phase_detector i_phase_detector (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.ref_tick_i  (ref_tick_i),
		.phase_i     (phase),
		.err_o       (err),
		.err_valid_o (err_valid)
	);

	// control code closes the loop back into the NCO
	adpll_loop_filter #(
		.DYNAMIC_GAIN (DYNAMIC_GAIN),
		.KP           (KP),
		.KI           (KI)
	) i_loop_filter (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.kp_i        (kp_i),
		.ki_i        (ki_i),
		.err_i       (err),
		.err_valid_i (err_valid),
		.dco_cc_o    (dco_cc_o)
	);

	adpll_lock_detector #(
		.LOCK_TOL   (LOCK_TOL),
		.LOCK_COUNT (LOCK_COUNT)
	) i_lock_detector (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.err_i       (err),
		.err_valid_i (err_valid),
		.lock_o      (lock_o)
	);

endmodule

//--- adpll_lock_detector.sv
`timescale 1ns/1ps

module adpll_lock_detector
#(
	parameter int LOCK_TOL = 2,
	parameter int LOCK_COUNT = 8
)
(
	input  logic              gen_clk_i,
	input  logic              reset_i,
	input  adpll_pkg::error_t err_i,
	input  logic              err_valid_i,
	output logic              lock_o
);

	localparam int EW = adpll_pkg::ERROR_WIDTH;
	localparam int CNT_WIDTH = $clog2(LOCK_COUNT + 1);

	logic signed [EW:0]     err_ext_c;
	logic [EW:0]            err_abs_c;
	logic                   in_tol_c;
	logic [CNT_WIDTH-1:0]   run_cnt_q;

	// one extra bit so that |-min| fits
	assign err_ext_c = err_i;
	assign err_abs_c = err_ext_c[EW] ? -err_ext_c : err_ext_c;
	assign in_tol_c = err_abs_c <= LOCK_TOL;

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			run_cnt_q <= '0;
			lock_o <= 1'b0;
		end
		else if (err_valid_i)
		begin
			if (in_tol_c)
			begin
				// counter parks at LOCK_COUNT once locked
				if (run_cnt_q != CNT_WIDTH'(LOCK_COUNT))
					run_cnt_q <= run_cnt_q + 1'b1;
				if (run_cnt_q >= CNT_WIDTH'(LOCK_COUNT - 1))
					lock_o <= 1'b1;
			end
			else
			begin
				run_cnt_q <= '0;
				lock_o <= 1'b0;
			end
		end
	end

endmodule

//--- adpll_loop_filter.sv
`timescale 1ns/1ps

module adpll_loop_filter
#(
	parameter int               DYNAMIC_GAIN = 1,
	parameter adpll_pkg::kp_t   KP = 3'b001,
	parameter adpll_pkg::ki_t   KI = 4'b0001
)
(
	input  logic               gen_clk_i,
	input  logic               reset_i,
	input  adpll_pkg::kp_t     kp_i,
	input  adpll_pkg::ki_t     ki_i,
	input  adpll_pkg::error_t  err_i,
	input  logic               err_valid_i,
	output adpll_pkg::dco_cc_t dco_cc_o
);

	localparam int EW = adpll_pkg::ERROR_WIDTH;
	localparam int IW = adpll_pkg::INTEG_WIDTH;
	localparam int CW = adpll_pkg::DCO_CC_WIDTH;
	localparam int KP_PROD_WIDTH = EW + adpll_pkg::KP_WIDTH + 1;
	localparam int KI_PROD_WIDTH = EW + adpll_pkg::KI_WIDTH + 1;
	// kp has fewer fraction bits than ki
	localparam int ALIGN = adpll_pkg::KI_FRAC_WIDTH - adpll_pkg::KP_FRAC_WIDTH;
	localparam int P_WIDTH = KP_PROD_WIDTH + ALIGN;
	localparam int SUM_WIDTH = IW + 1;
	localparam int SHIFT_WIDTH = SUM_WIDTH - adpll_pkg::KI_FRAC_WIDTH;
	localparam int CC_MAX = 2 ** (CW - 1) - 1;
	localparam int CC_MIN = -(2 ** (CW - 1));

	adpll_pkg::kp_t kp_x;
	adpll_pkg::ki_t ki_x;
	logic signed [adpll_pkg::KP_WIDTH:0] kp_s;
	logic signed [adpll_pkg::KI_WIDTH:0] ki_s;

	adpll_pkg::error_t        err_q;
	logic signed [IW-1:0]     integ_q;

	logic signed [KP_PROD_WIDTH-1:0] kp_prod_c;
	logic signed [KI_PROD_WIDTH-1:0] ki_prod_c;
	logic signed [P_WIDTH-1:0]       p_term_c;
	logic signed [SUM_WIDTH-1:0]     integ_sum_c;
	logic signed [IW-1:0]            integ_next_c;
	logic signed [SUM_WIDTH-1:0]     out_sum_c;
	logic signed [SHIFT_WIDTH-1:0]   out_shift_c;

	always_comb
	begin
		if (DYNAMIC_GAIN != 0)
		begin
			kp_x = kp_i;
			ki_x = ki_i;
		end
		else
		begin
			kp_x = KP;
			ki_x = KI;
		end
	end

	// gains are unsigned, widen by one bit for signed products
	assign kp_s = $signed({1'b0, kp_x});
	assign ki_s = $signed({1'b0, ki_x});

	// integral path works on the incoming error
	assign ki_prod_c = err_i * ki_s;
	assign integ_sum_c = SUM_WIDTH'(integ_q) + SUM_WIDTH'(ki_prod_c);

	always_comb
	begin
		if (integ_sum_c[SUM_WIDTH-1] != integ_sum_c[SUM_WIDTH-2])
		begin
			// overflow, clamp to the signed limit on the sum's side
			integ_next_c = {integ_sum_c[SUM_WIDTH-1], {(IW-1){~integ_sum_c[SUM_WIDTH-1]}}};
		end
		else
		begin
			integ_next_c = integ_sum_c[IW-1:0];
		end
	end

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			err_q <= '0;
			integ_q <= '0;
		end
		else if (err_valid_i)
		begin
			err_q <= err_i;
			integ_q <= integ_next_c;
		end
	end

	// proportional path on the registered error, moved to ki fraction bits
	assign kp_prod_c = err_q * kp_s;
	assign p_term_c = $signed({kp_prod_c, {ALIGN{1'b0}}});

	assign out_sum_c = SUM_WIDTH'(integ_q) + SUM_WIDTH'(p_term_c);
	assign out_shift_c = SHIFT_WIDTH'(out_sum_c >>> adpll_pkg::KI_FRAC_WIDTH);

	always_comb
	begin
		if (out_shift_c > CC_MAX)
			dco_cc_o = adpll_pkg::dco_cc_t'(CC_MAX);
		else if (out_shift_c < CC_MIN)
			dco_cc_o = adpll_pkg::dco_cc_t'(CC_MIN);
		else
			dco_cc_o = out_shift_c[CW-1:0];
	end

	// code only moves after an error update or a kp change
	a_cc_hold: assert property (@(posedge gen_clk_i) disable iff (reset_i)
		(!$past(err_valid_i) && $stable(kp_x)) |-> $stable(dco_cc_o))
		else $error("dco_cc_o changed without an error update");

endmodule

//--- adpll_phase_detector.sv
`timescale 1ns/1ps

module adpll_phase_detector
(
	input  logic              gen_clk_i,
	input  logic              reset_i,
	input  logic              ref_tick_i,
	input  adpll_pkg::phase_t phase_i,
	output adpll_pkg::error_t err_o,
	output logic              err_valid_o
);

	localparam int EW = adpll_pkg::ERROR_WIDTH;
	localparam int PW = adpll_pkg::PHASE_WIDTH;

	adpll_pkg::error_t sample_c;
	adpll_pkg::error_t err_c;

	// coarse phase, top bits read as a signed fraction of a turn
	assign sample_c = $signed(phase_i[PW-1:PW-EW]);

	// target phase is zero, so the error is the negated sample
	always_comb
	begin
		if (sample_c == {1'b1, {(EW-1){1'b0}}})
		begin
			// -min does not fit, clamp to +max
			err_c = {1'b0, {(EW-1){1'b1}}};
		end
		else
		begin
			err_c = -sample_c;
		end
	end

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			err_valid_o <= 1'b0;
		end
		else
		begin
			err_valid_o <= ref_tick_i;
		end
	end

	always_ff @(posedge gen_clk_i)
	begin
		if (ref_tick_i)
		begin
			err_o <= err_c;
		end
	end

	// negation saturates, a valid error never carries the most negative code
	a_err_no_min: assert property (@(posedge gen_clk_i) disable iff (reset_i)
		err_valid_o |-> err_o != {1'b1, {(EW-1){1'b0}}})
		else $error("err_o holds the most negative code with err_valid_o high");

endmodule

//--- adpll_nco.sv
`timescale 1ns/1ps

module adpll_nco
(
	input  logic               gen_clk_i,
	input  logic               reset_i,
	input  adpll_pkg::phase_t  fcw_i,
	input  adpll_pkg::dco_cc_t dco_cc_i,
	output adpll_pkg::phase_t  phase_o,
	output logic               tick_o
);

	localparam int PW = adpll_pkg::PHASE_WIDTH;
	// three guard bits, two for carries of a step past full scale and one for the sign
	localparam int ACC_WIDTH = PW + 3;
	localparam int HALF_SCALE = 2 ** (PW - 1);

	logic signed [ACC_WIDTH-1:0] step_c;
	logic signed [ACC_WIDTH-1:0] acc_c;
	logic                        carry_c;

	// base word trimmed by the loop filter
	assign step_c = $signed({3'b000, fcw_i}) + ACC_WIDTH'(dco_cc_i);
	assign acc_c = $signed({3'b000, phase_o}) + step_c;

	// carry past full scale, a backward step never counts
	assign carry_c = !acc_c[ACC_WIDTH-1] && (acc_c[ACC_WIDTH-2:PW] != '0);

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			phase_o <= '0;
			tick_o <= 1'b0;
		end
		else
		begin
			phase_o <= acc_c[PW-1:0];
			tick_o <= carry_c;
		end
	end

	// a step below half a turn cannot wrap twice in a row
	a_no_double_tick: assert property (@(posedge gen_clk_i) disable iff (reset_i)
		(tick_o && step_c < HALF_SCALE && $past(step_c) < HALF_SCALE) |=> !tick_o)
		else $error("tick_o high for two cycles with a step below half scale");

endmodule

//--- adpll_pkg.sv
package adpll_pkg;

	// phase error from the detector
	localparam int ERROR_WIDTH = 8;

	// control code fed back to the oscillator
	localparam int DCO_CC_WIDTH = 9;

	// phase accumulator and frequency word
	localparam int PHASE_WIDTH = 16;

	// proportional gain, unsigned with one fraction bit
	localparam int KP_WIDTH = 3;
	localparam int KP_FRAC_WIDTH = 1;

	// integral gain, unsigned with three fraction bits
	localparam int KI_WIDTH = 4;
	localparam int KI_FRAC_WIDTH = 3;

	// integrator keeps KI_FRAC_WIDTH fraction bits
	localparam int INTEG_WIDTH = 20;

	typedef logic signed [ERROR_WIDTH-1:0] error_t;

	typedef logic signed [DCO_CC_WIDTH-1:0] dco_cc_t;

	typedef logic [PHASE_WIDTH-1:0] phase_t;

	typedef logic [KP_WIDTH-1:0] kp_t;

	typedef logic [KI_WIDTH-1:0] ki_t;

endpackage
